// ==== hdl/boot_cfg_pkg.sv ====
package boot_cfg_pkg;

  localparam int NUM_CORES     = 8;
  localparam int NUM_SLOTS     = 16;
  localparam int CORE_NO_WIDTH = 3;
  localparam int SLOT_NO_WIDTH = 4;

  localparam int AXI_ADDR_WIDTH = 19;
  localparam int AXI_DATA_WIDTH = 64;
  localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

  localparam logic [7:0] AXI_ID = 8'h00;

  // control word sits at the top of each core's 64 KB window.
  localparam logic [AXI_ADDR_WIDTH-CORE_NO_WIDTH-1:0] CORE_CTRL_OFFSET = 16'hfff8;
  localparam logic [AXI_STRB_WIDTH-1:0] RELEASE_STRB = 8'h80; // reset bit lives in the top byte.

  localparam int SLOT_ADDR_WIDTH = 7;
  localparam logic [SLOT_ADDR_WIDTH-1:0] FIRST_SLOT_ADDR = 7'h40;
  localparam logic [SLOT_ADDR_WIDTH-1:0] SLOT_ADDR_STEP  = 7'h04;

  localparam int START_DELAY = 1000; // cycles after reset before anything moves.

endpackage

// ==== hdl/boot_types_pkg.sv ====
package boot_types_pkg;
  import boot_cfg_pkg::*;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  typedef struct packed {
    logic [7:0]                id;
    logic [AXI_ADDR_WIDTH-1:0] addr;
    logic [7:0]                len;
    logic [2:0]                size;
    logic [1:0]                burst;
  } axi_aw_t;

  typedef struct packed {
    logic [AXI_DATA_WIDTH-1:0] data;
    logic [AXI_STRB_WIDTH-1:0] strb;
    logic                      last;
  } axi_w_t;

  typedef struct packed {
    logic [7:0] id;
    axi_resp_e  resp;
  } axi_b_t;

  typedef struct packed {
    logic [SLOT_NO_WIDTH-1:0]   slot_no;
    logic [SLOT_ADDR_WIDTH-1:0] slot_addr;
  } slot_wr_t;

  typedef struct packed {
    logic [CORE_NO_WIDTH-1:0] core_no;
    logic [SLOT_NO_WIDTH-1:0] slot_no;
  } rx_desc_t;

  typedef enum logic [1:0] {
    BOOT_DELAY,
    BOOT_INIT,
    BOOT_RUN
  } boot_state_e;

  typedef enum logic [1:0] {
    REL_IDLE,
    REL_ISSUE,
    REL_RESP,
    REL_DONE
  } release_state_e;

endpackage

// ==== hdl/boot_enable_ctrl.sv ====
`timescale 1ns/100ps

module boot_enable_ctrl (
  input  logic clk,
  input  logic rst,
  output logic start,
  input  logic release_done,
  input  logic init_done,
  output logic tx_enable,
  output logic rx_enable
);
  import boot_cfg_pkg::*;
  import boot_types_pkg::*;

  boot_state_e                    state;
  logic [$clog2(START_DELAY)-1:0] delay_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= BOOT_DELAY;
      delay_cnt <= '0;
      start     <= 1'b0;
    end else begin
      start <= 1'b0;
      case (state)
        BOOT_DELAY: begin
          if (delay_cnt == $bits(delay_cnt)'(START_DELAY - 1)) begin
            state <= BOOT_INIT;
            start <= 1'b1; // one pulse kicks off both workers.
          end else begin
            delay_cnt <= delay_cnt + 1'b1;
          end
        end
        BOOT_INIT: begin
          if (release_done && init_done)
            state <= BOOT_RUN;
        end
        BOOT_RUN: state <= BOOT_RUN; // held until reset.
        default:  state <= BOOT_DELAY;
      endcase
    end
  end

  assign tx_enable = (state == BOOT_RUN);
  assign rx_enable = (state == BOOT_RUN);

  a_start_pulse: assert property (@(posedge clk) disable iff (rst)
    start |=> !start);

  a_enable_hold: assert property (@(posedge clk) disable iff (rst)
    tx_enable && rx_enable |=> tx_enable && rx_enable);

endmodule

// ==== hdl/core_release_writer.sv ====
`timescale 1ns/100ps

module core_release_writer (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  output boot_types_pkg::axi_aw_t aw,
  output logic                    aw_valid,
  input  logic                    aw_ready,
  output boot_types_pkg::axi_w_t  w,
  output logic                    w_valid,
  input  logic                    w_ready,
  input  boot_types_pkg::axi_b_t  b,
  input  logic                    b_valid,
  output logic                    b_ready,
  output logic                    done
);
  import boot_cfg_pkg::*;
  import boot_types_pkg::*;

  release_state_e           state;
  logic [CORE_NO_WIDTH-1:0] core_no;
  logic                     aw_fire;
  logic                     w_fire;
  logic                     resp_ok;
  logic                     last_core;

  assign aw_fire   = aw_valid && aw_ready;
  assign w_fire    = w_valid && w_ready;
  assign resp_ok   = (b.resp == OKAY) || (b.resp == EXOKAY);
  assign last_core = (core_no == CORE_NO_WIDTH'(NUM_CORES - 1));

  // payload is built from the core counter, so it holds while stalled.
  assign aw.id    = AXI_ID;
  assign aw.addr  = {core_no, CORE_CTRL_OFFSET};
  assign aw.len   = 8'd0; // single beat.
  assign aw.size  = 3'($clog2(AXI_STRB_WIDTH));
  assign aw.burst = 2'b01; // incr.

  assign w.data = '0;
  assign w.strb = RELEASE_STRB;
  assign w.last = 1'b1;

  assign b_ready = (state == REL_RESP);
  assign done    = (state == REL_DONE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= REL_IDLE;
      core_no  <= '0;
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
    end else begin
      case (state)
        REL_IDLE: begin
          if (start) begin
            state    <= REL_ISSUE;
            aw_valid <= 1'b1;
            w_valid  <= 1'b1;
          end
        end
        REL_ISSUE: begin
          if (aw_fire)
            aw_valid <= 1'b0;
          if (w_fire)
            w_valid <= 1'b0;
          // both channels done earlier or on this edge.
          if ((!aw_valid || aw_ready) && (!w_valid || w_ready))
            state <= REL_RESP;
        end
        REL_RESP: begin
          if (b_valid) begin
            if (resp_ok && last_core) begin
              state <= REL_DONE;
            end else begin
              state    <= REL_ISSUE; // next core, or the same one again on error.
              aw_valid <= 1'b1;
              w_valid  <= 1'b1;
              if (resp_ok)
                core_no <= core_no + 1'b1;
            end
          end
        end
        REL_DONE: state <= REL_DONE;
        default:  state <= REL_IDLE;
      endcase
    end
  end

  a_aw_stable: assert property (@(posedge clk) disable iff (rst)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw));

  a_w_stable: assert property (@(posedge clk) disable iff (rst)
    w_valid && !w_ready |=> w_valid && $stable(w));

  // a response only shows up once both address and data have gone out.
  a_b_in_resp: assert property (@(posedge clk) disable iff (rst)
    b_valid |-> state == REL_RESP);

endmodule

// ==== hdl/slot_desc_init.sv ====
`timescale 1ns/100ps

module slot_desc_init (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  output boot_types_pkg::slot_wr_t slot_wr,
  output logic                     slot_wr_valid,
  output boot_types_pkg::rx_desc_t rx_desc,
  output logic                     rx_desc_valid,
  input  logic                     rx_desc_ready,
  output logic                     done
);
  import boot_cfg_pkg::*;

  logic [SLOT_NO_WIDTH-1:0]   slot_cnt;
  logic [SLOT_ADDR_WIDTH-1:0] slot_addr;
  logic [CORE_NO_WIDTH-1:0]   desc_core;
  logic [SLOT_NO_WIDTH-1:0]   desc_slot;
  logic                       table_last;
  logic                       desc_fire;
  logic                       desc_last_core;
  logic                       desc_last_slot;

  assign table_last     = slot_wr_valid && (slot_cnt == SLOT_NO_WIDTH'(NUM_SLOTS - 1));
  assign desc_fire      = rx_desc_valid && rx_desc_ready;
  assign desc_last_core = (desc_core == CORE_NO_WIDTH'(NUM_CORES - 1));
  assign desc_last_slot = (desc_slot == SLOT_NO_WIDTH'(NUM_SLOTS - 1));

  assign slot_wr.slot_no   = slot_cnt;
  assign slot_wr.slot_addr = slot_addr;
  assign rx_desc.core_no   = desc_core;
  assign rx_desc.slot_no   = desc_slot;

  always_ff @(posedge clk) begin
    if (rst) begin
      slot_wr_valid <= 1'b0;
      slot_cnt      <= '0;
    end else if (start) begin
      slot_wr_valid <= 1'b1;
      slot_cnt      <= '0;
    end else if (slot_wr_valid) begin
      slot_cnt <= slot_cnt + 1'b1;
      if (table_last)
        slot_wr_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start)
      slot_addr <= FIRST_SLOT_ADDR;
    else if (slot_wr_valid)
      slot_addr <= slot_addr + SLOT_ADDR_STEP;
  end

  // core steps fastest, slot wraps slower.
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_desc_valid <= 1'b0;
      desc_core     <= '0;
      desc_slot     <= '0;
      done          <= 1'b0;
    end else if (table_last) begin
      rx_desc_valid <= 1'b1;
    end else if (desc_fire) begin
      desc_core <= desc_core + 1'b1;
      if (desc_last_core)
        desc_slot <= desc_slot + 1'b1;
      if (desc_last_core && desc_last_slot) begin
        rx_desc_valid <= 1'b0;
        done          <= 1'b1;
      end
    end
  end

  a_desc_stable: assert property (@(posedge clk) disable iff (rst)
    rx_desc_valid && !rx_desc_ready |=> rx_desc_valid && $stable(rx_desc));

endmodule

// ==== hdl/boot_ctrl_top.sv ====
`timescale 1ns/100ps

module boot_ctrl_top (
  input  logic                     clk,
  input  logic                     rst,
  output boot_types_pkg::axi_aw_t  aw,
  output logic                     aw_valid,
  input  logic                     aw_ready,
  output boot_types_pkg::axi_w_t   w,
  output logic                     w_valid,
  input  logic                     w_ready,
  input  boot_types_pkg::axi_b_t   b,
  input  logic                     b_valid,
  output logic                     b_ready,
  output boot_types_pkg::slot_wr_t slot_wr,
  output logic                     slot_wr_valid,
  output boot_types_pkg::rx_desc_t rx_desc,
  output logic                     rx_desc_valid,
  input  logic                     rx_desc_ready,
  output logic                     tx_enable,
  output logic                     rx_enable
);

  logic start;
  logic release_done;
  logic init_done;

  boot_enable_ctrl enable_ctrl_i (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .release_done (release_done),
    .init_done    (init_done),
    .tx_enable    (tx_enable),
    .rx_enable    (rx_enable)
  );

  core_release_writer release_writer_i (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .done     (release_done)
  );

  slot_desc_init slot_init_i (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .slot_wr       (slot_wr),
    .slot_wr_valid (slot_wr_valid),
    .rx_desc       (rx_desc),
    .rx_desc_valid (rx_desc_valid),
    .rx_desc_ready (rx_desc_ready),
    .done          (init_done)
  );

endmodule

// ==== verif/boot_ctrl_checks.svh ====
`ifndef BOOT_CTRL_CHECKS_SVH
`define BOOT_CTRL_CHECKS_SVH

task automatic stop_run(input string msg);
  $display("%s", msg);
  $display("Something failed");
  $fatal(1);
endtask

task automatic compare_aw(input string name, input axi_aw_t exp, input axi_aw_t act);
  if (act !== exp)
    stop_run($sformatf("FAILED %s: expected 0x%0h, got 0x%0h", name, exp, act));
endtask

task automatic compare_w(input string name, input axi_w_t exp, input axi_w_t act);
  if (act !== exp)
    stop_run($sformatf("FAILED %s: expected 0x%0h, got 0x%0h", name, exp, act));
endtask

// slot number in the upper bits, address below.
task automatic compare_slot_wr(input string name, input slot_wr_t exp, input slot_wr_t act);
  if (act !== exp)
    stop_run($sformatf("FAILED %s: expected 0x%0h, got 0x%0h", name, exp, act));
endtask

task automatic compare_desc(input string name, input rx_desc_t exp, input rx_desc_t act);
  if (act !== exp)
    stop_run($sformatf("FAILED %s: expected 0x%0h, got 0x%0h", name, exp, act));
endtask

task automatic compare_flag(input string name, input logic exp, input logic act);
  if (act !== exp)
    stop_run($sformatf("FAILED %s: expected 0x%0h, got 0x%0h", name, exp, act));
endtask

`endif

// ==== verif/boot_ctrl_tb.sv ====
`timescale 1ns/100ps

module boot_ctrl_tb;
  import boot_cfg_pkg::*;
  import boot_types_pkg::*;

  localparam int TIMEOUT_CYCLES = 6 * (START_DELAY + 400);
  localparam int NUM_DESCS      = NUM_CORES * NUM_SLOTS;

  logic     clk = 1'b0;
  logic     rst;
  logic     aw_valid, aw_ready;
  logic     w_valid, w_ready;
  logic     b_valid, b_ready;
  logic     slot_wr_valid;
  logic     rx_desc_valid, rx_desc_ready;
  logic     tx_enable, rx_enable;
  axi_aw_t  aw;
  axi_w_t   w;
  axi_b_t   b;
  slot_wr_t slot_wr;
  rx_desc_t rx_desc;
  integer   seed;
  int       cycle_count = 0;

  `include "boot_ctrl_checks.svh"

  boot_ctrl_top dut_i (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES)
      stop_run("timeout: the boot sequence never finished");
  end

  task automatic reset_dut();
    rst           <= 1'b1;
    aw_ready      <= 1'b1;
    w_ready       <= 1'b1;
    b             <= '0;
    b_valid       <= 1'b0;
    rx_desc_ready <= 1'b0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  endtask

  // one full boot with responder, consumer and monitors stepped per cycle.
  task automatic run_boot(input bit axi_stall, input int err_core, input int desc_mode);
    int       writes = 0, beats = 0;
    int       releases = 0, exp_core = 0;
    int       slots = 0, descs = 0;
    int       hold = 0, done_age = 0;
    bit       aw_seen = 0, w_seen = 0, err_given = 0;
    bit       aw_wait = 0, w_wait = 0, desc_wait = 0;
    axi_aw_t  aw_held, exp_aw;
    axi_w_t   w_held, exp_w;
    rx_desc_t desc_held, exp_desc;
    slot_wr_t exp_slot;
    reset_dut();
    repeat (START_DELAY) begin
      @(posedge clk);
      compare_flag("aw_valid", 1'b0, aw_valid);
      compare_flag("w_valid", 1'b0, w_valid);
      compare_flag("b_ready", 1'b0, b_ready);
      compare_flag("slot_wr_valid", 1'b0, slot_wr_valid);
      compare_flag("rx_desc_valid", 1'b0, rx_desc_valid);
      compare_flag("tx_enable", 1'b0, tx_enable);
      compare_flag("rx_enable", 1'b0, rx_enable);
    end
    while (done_age < 12) begin
      @(posedge clk);
      // a response is expected exactly while the responder holds one out.
      compare_flag("b_ready", b_valid, b_ready);
      if (aw_wait) begin
        compare_flag("aw_valid", 1'b1, aw_valid);
        compare_aw("aw", aw_held, aw);
      end
      if (w_wait) begin
        compare_flag("w_valid", 1'b1, w_valid);
        compare_w("w", w_held, w);
      end
      if (desc_wait) begin
        compare_flag("rx_desc_valid", 1'b1, rx_desc_valid);
        compare_desc("rx_desc", desc_held, rx_desc);
      end
      aw_wait   = aw_valid && !aw_ready;
      w_wait    = w_valid && !w_ready;
      desc_wait = rx_desc_valid && !rx_desc_ready;
      aw_held   = aw;
      w_held    = w;
      desc_held = rx_desc;
      if (aw_valid && aw_ready) begin
        exp_aw = '{id: AXI_ID, addr: {exp_core[CORE_NO_WIDTH-1:0], CORE_CTRL_OFFSET},
                   len: 8'd0, size: 3'd3, burst: 2'b01}; // 8-byte beat, incr.
        compare_aw("aw", exp_aw, aw);
        writes++;
        aw_seen = 1;
      end
      if (w_valid && w_ready) begin
        exp_w = '{data: '0, strb: RELEASE_STRB, last: 1'b1};
        compare_w("w", exp_w, w);
        beats++;
        w_seen = 1;
      end
      if (b_valid && b_ready) begin
        if (b.resp == OKAY) begin
          exp_core++;
          releases++;
        end
        b_valid <= 1'b0;
      end else if (aw_seen && w_seen && !b_valid) begin
        b       <= '{id: AXI_ID, resp: (exp_core == err_core && !err_given) ? SLVERR : OKAY};
        b_valid <= 1'b1;
        err_given = err_given || (exp_core == err_core);
        aw_seen   = 0;
        w_seen    = 0;
      end
      if (slot_wr_valid) begin
        exp_slot = '{slot_no: SLOT_NO_WIDTH'(slots),
                     slot_addr: SLOT_ADDR_WIDTH'(FIRST_SLOT_ADDR + slots * SLOT_ADDR_STEP)};
        compare_slot_wr("slot_wr", exp_slot, slot_wr);
        slots++;
      end
      if (rx_desc_valid && rx_desc_ready) begin
        exp_desc = '{core_no: CORE_NO_WIDTH'(descs % NUM_CORES),
                     slot_no: SLOT_NO_WIDTH'(descs / NUM_CORES)};
        compare_desc("rx_desc", exp_desc, rx_desc);
        descs++;
      end
      // done rises one cycle after the last job ends, the enables one cycle later.
      compare_flag("tx_enable", done_age >= 2, tx_enable);
      compare_flag("rx_enable", done_age >= 2, rx_enable);
      if (descs == NUM_DESCS && releases == NUM_CORES)
        done_age++;
      if (releases == NUM_CORES)
        hold++;
      aw_ready <= axi_stall ? 1'($random(seed)) : 1'b1;
      w_ready  <= axi_stall ? 1'($random(seed)) : 1'b1;
      case (desc_mode)
        0:       rx_desc_ready <= 1'b1;
        1:       rx_desc_ready <= 1'($random(seed));
        default: rx_desc_ready <= (hold > 20); // held off well past the release writes.
      endcase
    end
    if (writes != NUM_CORES + (err_core >= 0) || beats != writes)
      stop_run($sformatf("FAILED aw/w handshakes: expected 0x%0h, got 0x%0h/0x%0h",
                         NUM_CORES + (err_core >= 0), writes, beats));
    if (slots != NUM_SLOTS)
      stop_run($sformatf("FAILED slot_wr_valid: expected 0x%0h, got 0x%0h", NUM_SLOTS, slots));
  endtask

  task automatic basic_boot_test();
    run_boot(1'b0, -1, 0);
  endtask

  task automatic stalled_boot_test();
    run_boot(1'b1, 3, 1); // first response for core 3 is an error.
  endtask

  task automatic held_desc_test();
    run_boot(1'b0, -1, 2);
  endtask

  initial begin
    seed = 32'hd9a6_1141;
    basic_boot_test();
    stalled_boot_test();
    held_desc_test();
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+verif
hdl/boot_cfg_pkg.sv
hdl/boot_types_pkg.sv
hdl/boot_enable_ctrl.sv
hdl/core_release_writer.sv
hdl/slot_desc_init.sv
hdl/boot_ctrl_top.sv
verif/boot_ctrl_tb.sv
